// ==== tb.f ====
design/latsc_pkg.sv
design/sync_fifo.sv
design/fence_filter.sv
design/latency_slot_array.sv
design/latency_scoreboard.sv
test/tb_latency_scoreboard.sv

// ==== Makefile ====
# Verilator flow for the latency scoreboard
TOP = tb_latency_scoreboard

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
		--top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== test/tb_latency_scoreboard.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the latency scoreboard
//   Clock, reset, Galois LFSR stimulus source
//   Reference model table indexed by tag, with fence epochs
//   Compare tasks per result kind, output monitor, watchdog
//   Tests for reset state, single request, random traffic, back-pressure
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_latency_scoreboard;

   localparam int HDR_W          = 24;
   localparam int DATA_W         = 32;
   localparam int TID_W          = latsc_pkg::TID_WIDTH;
   localparam int CLK_PERIOD     = 20;
   localparam int MAX_TAGS       = 4096;
   localparam int TRAFFIC_CYCLES = 500;
   localparam int BP_LIMIT       = 400;
   localparam int BP_HOLD        = 30;
   localparam int DRAIN_LIMIT    = 4000;
   localparam int IDLE_LIMIT     = 50;
   // Test lengths summed, scaled by the longest delay bound
   localparam int WATCHDOG_NS    = (1 + TRAFFIC_CYCLES + BP_LIMIT + BP_HOLD) *
                                   latsc_pkg::LAT_MAX_RD * CLK_PERIOD;

   logic              clk;
   logic              rst;
   logic [HDR_W-1:0]  meta_i;
   logic [DATA_W-1:0] data_i;
   logic              write_en_i;
   logic              read_en_i;
   logic [HDR_W-1:0]  meta_o;
   logic [DATA_W-1:0] data_o;
   logic [TID_W-1:0]  tid_o;
   logic              valid_o;
   logic              empty_o;
   logic              full_o;
   logic              overflow_o;
   logic              underflow_o;
   logic [31:0]       count_o;

   // Model table, one entry per tag
   logic [HDR_W-1:0]  exp_hdr       [MAX_TAGS];
   logic [DATA_W-1:0] exp_data      [MAX_TAGS];
   int                exp_cycle     [MAX_TAGS];
   int                exp_epoch     [MAX_TAGS];
   logic              exp_open      [MAX_TAGS];
   // Requests still in flight per fence epoch
   int                epoch_pending [MAX_TAGS];

   int                wr_tag;
   int                epoch;
   int                pending;
   int                req_total;
   int                out_total;
   logic [TID_W-1:0]  last_tid;
   logic              saw_overflow;
   logic [15:0]       lfsr_state;
   int                cycle;
   string             test_name;
   int                errors;
   int                checks;
   int                tests_run;
   int                err_at_start;
   int                reqs_at_start;
   int                outs_at_start;

   latency_scoreboard #(
      .HDR_WIDTH(HDR_W), .DATA_WIDTH(DATA_W), .NUM_SLOTS(8),
      .IN_DEPTH_LOG2(5), .IN_FULL_THRESH(24), .Q_DEPTH_LOG2(3), .Q_FULL_THRESH(5),
      .LFSR_SEED(16'h5A3C)
   ) UUT (
      .clk(clk), .rst(rst),
      .meta_i(meta_i), .data_i(data_i), .write_en_i(write_en_i),
      .meta_o(meta_o), .data_o(data_o), .tid_o(tid_o), .valid_o(valid_o),
      .read_en_i(read_en_i), .empty_o(empty_o), .full_o(full_o),
      .overflow_o(overflow_o), .underflow_o(underflow_o), .count_o(count_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk)
      cycle <= cycle + 1;

   // Galois LFSR, taps 16 15 13 4
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {1'b0, s[15:1]} ^ (s[0] ? 16'hD008 : 16'h0000);
   endfunction

   // One LFSR step per bit taken
   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v          = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // Lower delay bound of the opcode in a header
   function automatic int min_delay(input logic [HDR_W-1:0] hdr);
      case (hdr[latsc_pkg::TYPE_LSB +: latsc_pkg::TYPE_WIDTH])
         latsc_pkg::RD_LINE: return latsc_pkg::LAT_MIN_RD;
         latsc_pkg::WR_LINE: return latsc_pkg::LAT_MIN_WR;
         latsc_pkg::WR_THRU: return latsc_pkg::LAT_MIN_WT;
         latsc_pkg::INTR:    return latsc_pkg::LAT_MIN_INT;
         default:            return latsc_pkg::LAT_UNDEF;
      endcase
   endfunction

   task automatic report_error(input string msg);
      errors++;
      $display("error in %s: %s", test_name, msg);
   endtask

   task automatic compare_header(input string what, input logic [HDR_W-1:0] exp,
                                 input logic [HDR_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic compare_data(input string what, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic compare_tag(input string what, input logic [TID_W-1:0] exp,
                              input logic [TID_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
      end
   endtask

   task automatic compare_count(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
      end
   endtask

   task automatic compare_flag(input string what, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
      end
   endtask

   // Random request into the model table and onto the DUT inputs
   task automatic issue_request();
      logic [31:0]           r;
      logic [HDR_W-1:0]      hdr;
      latsc_pkg::req_type_e  op;
      rand_bits(3, r);
      case (r[2:0])
         3'd0, 3'd5: op = latsc_pkg::RD_LINE;
         3'd1, 3'd6: op = latsc_pkg::WR_LINE;
         3'd2, 3'd7: op = latsc_pkg::WR_THRU;
         3'd3:       op = latsc_pkg::WR_FENCE;
         default:    op = latsc_pkg::INTR;
      endcase
      rand_bits(HDR_W - latsc_pkg::TYPE_WIDTH, r);
      hdr = HDR_W'(r << latsc_pkg::TYPE_WIDTH);
      hdr[latsc_pkg::TYPE_LSB +: latsc_pkg::TYPE_WIDTH] = op;
      rand_bits(DATA_W, r);
      exp_hdr[wr_tag]   = hdr;
      exp_data[wr_tag]  = r;
      exp_cycle[wr_tag] = cycle;
      exp_epoch[wr_tag] = epoch;
      // Fence opens a new epoch and never reaches the output
      if (op == latsc_pkg::WR_FENCE) begin
         exp_open[wr_tag] = 1'b0;
         epoch++;
      end else begin
         exp_open[wr_tag] = 1'b1;
         epoch_pending[epoch]++;
         pending++;
         req_total++;
      end
      wr_tag++;
      meta_i = hdr;
      data_i = r;
   endtask

   // One cycle, inputs driven just after the edge, writer obeys full_o
   task automatic step(input logic do_write, input logic do_read);
      @(posedge clk);
      #2;
      read_en_i  = do_read;
      write_en_i = 1'b0;
      if (do_write && !full_o) begin
         issue_request();
         write_en_i = 1'b1;
      end
   endtask

   // Output word against the model entry of its tag
   task automatic check_output();
      int   tid;
      int   lat;
      logic early_epoch;
      tid      = int'(tid_o);
      last_tid = tid_o;
      out_total++;
      if (tid >= wr_tag) begin
         report_error($sformatf("tag %0d left the model but was never written", tid));
      end else if (exp_hdr[tid][latsc_pkg::TYPE_LSB +: latsc_pkg::TYPE_WIDTH] ==
                   latsc_pkg::WR_FENCE) begin
         report_error($sformatf("fence with tag %0d appeared at the output", tid));
      end else if (!exp_open[tid]) begin
         report_error($sformatf("tag %0d left the model a second time", tid));
      end else begin
         compare_header("header", exp_hdr[tid], meta_o);
         compare_data("data", exp_data[tid], data_o);
         checks++;
         lat = cycle - exp_cycle[tid];
         if (lat < min_delay(exp_hdr[tid]) + 6)
            report_error($sformatf("tag %0d left after %0d cycles, minimum is %0d",
                                   tid, lat, min_delay(exp_hdr[tid]) + 6));
         // Everything before an earlier fence must be gone already
         checks++;
         early_epoch = 1'b0;
         for (int e = 0; e < exp_epoch[tid]; e++)
            if (epoch_pending[e] != 0)
               early_epoch = 1'b1;
         if (early_epoch)
            report_error($sformatf("tag %0d overtook a request from before a fence", tid));
         exp_open[tid] = 1'b0;
         epoch_pending[exp_epoch[tid]]--;
         pending--;
      end
   endtask

   // Outputs are stable at the falling edge
   always @(negedge clk) begin
      if (!rst) begin
         if (valid_o)
            check_output();
         if (overflow_o)
            saw_overflow = 1'b1;
      end
   end

   task automatic wait_drain(input logic rd_random);
      logic [31:0] r;
      logic        rd;
      int          n;
      n = 0;
      while (pending != 0 && n < DRAIN_LIMIT) begin
         rd = 1'b1;
         if (rd_random) begin
            rand_bits(2, r);
            rd = (r[1:0] != 2'b00);
         end
         step(1'b0, rd);
         n++;
      end
      if (pending != 0)
         report_error($sformatf("%0d requests still inside after %0d cycles",
                                pending, DRAIN_LIMIT));
   endtask

   // Trailing fences leave a few cycles after the last output
   task automatic wait_idle();
      int n;
      n = 0;
      while ((count_o != 32'd0 || !empty_o) && n < IDLE_LIMIT) begin
         step(1'b0, 1'b1);
         n++;
      end
      compare_count("count_o", 32'd0, count_o);
      compare_flag("empty_o", 1'b1, empty_o);
   endtask

   task automatic begin_test(input string name);
      test_name     = name;
      err_at_start  = errors;
      reqs_at_start = req_total;
      outs_at_start = out_total;
      saw_overflow  = 1'b0;
   endtask

   task automatic end_test();
      int errs;
      errs = errors - err_at_start;
      tests_run++;
      if (errs == 0)
         $display("test %s: ok", test_name);
      else
         $display("test %s: failed with %0d errors", test_name, errs);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: run still busy after %0d ns", WATCHDOG_NS);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      logic [31:0]      r;
      logic             saw_full;
      int               n;
      logic [TID_W-1:0] first_tag;
      rst          = 1'b1;
      meta_i       = '0;
      data_i       = '0;
      write_en_i   = 1'b0;
      read_en_i    = 1'b0;
      lfsr_state   = 16'd34774;
      cycle        = 0;
      wr_tag       = 0;
      epoch        = 0;
      pending      = 0;
      req_total    = 0;
      out_total    = 0;
      last_tid     = '0;
      saw_overflow = 1'b0;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      test_name    = "init";
      for (int i = 0; i < MAX_TAGS; i++) begin
         exp_open[i]      = 1'b0;
         epoch_pending[i] = 0;
      end
      repeat (5) @(posedge clk);
      #2;
      rst = 1'b0;

      begin_test("reset_state");
      compare_flag("empty_o", 1'b1, empty_o);
      compare_count("count_o", 32'd0, count_o);
      compare_flag("full_o", 1'b0, full_o);
      compare_flag("valid_o", 1'b0, valid_o);
      compare_flag("overflow_o", 1'b0, overflow_o);
      compare_flag("underflow_o", 1'b0, underflow_o);
      // A read of the empty model pulses underflow_o for one cycle
      step(1'b0, 1'b1);
      step(1'b0, 1'b0);
      compare_flag("underflow_o after empty read", 1'b1, underflow_o);
      step(1'b0, 1'b0);
      compare_flag("underflow_o one cycle", 1'b0, underflow_o);
      end_test();

      // Tags count every write from 0, fences included
      begin_test("single_req");
      n = 0;
      while (req_total == reqs_at_start && n < IDLE_LIMIT) begin
         step(1'b1, 1'b1);
         n++;
      end
      if (req_total == reqs_at_start)
         report_error("no ordinary request was issued");
      first_tag = TID_W'(wr_tag - 1);
      wait_drain(1'b0);
      compare_tag("first tag", first_tag, last_tid);
      compare_count("outputs", 32'(req_total - reqs_at_start), 32'(out_total - outs_at_start));
      wait_idle();
      end_test();

      begin_test("random_traffic");
      for (int i = 0; i < TRAFFIC_CYCLES; i++) begin
         rand_bits(2, r);
         step(r[1:0] != 2'b00, 1'b1);
      end
      wait_drain(1'b0);
      compare_count("outputs", 32'(req_total - reqs_at_start), 32'(out_total - outs_at_start));
      compare_flag("overflow_o seen", 1'b0, saw_overflow);
      wait_idle();
      end_test();

      // Reads held off until the input FIFO reports full
      begin_test("back_pressure");
      saw_full = 1'b0;
      n        = 0;
      while (!saw_full && n < BP_LIMIT) begin
         rand_bits(1, r);
         step(r[0], 1'b0);
         if (full_o)
            saw_full = 1'b1;
         n++;
      end
      if (!saw_full)
         report_error("full_o never rose while reads were held off");
      repeat (BP_HOLD) step(1'b1, 1'b0);
      wait_drain(1'b1);
      compare_count("outputs", 32'(req_total - reqs_at_start), 32'(out_total - outs_at_start));
      compare_flag("overflow_o seen", 1'b0, saw_overflow);
      wait_idle();
      end_test();

      $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== design/latency_scoreboard.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Latency scoreboard top level
//   Request tagging, input FIFO, fence filter, request FIFO
//   Latency slot array and output FIFO
//   Status flags and total occupancy
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module latency_scoreboard #(
   parameter int          HDR_WIDTH      = 24,
   parameter int          DATA_WIDTH     = 32,
   parameter int          NUM_SLOTS      = 8,
   parameter int          IN_DEPTH_LOG2  = 5,
   parameter int          IN_FULL_THRESH = 24,
   parameter int          Q_DEPTH_LOG2   = 3,
   parameter int          Q_FULL_THRESH  = 5,
   parameter logic [15:0] LFSR_SEED      = 16'hACE1
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [HDR_WIDTH-1:0]           meta_i,
   input  logic [DATA_WIDTH-1:0]          data_i,
   input  logic                           write_en_i,
   output logic [HDR_WIDTH-1:0]           meta_o,
   output logic [DATA_WIDTH-1:0]          data_o,
   output logic [latsc_pkg::TID_WIDTH-1:0] tid_o,
   output logic                           valid_o,
   input  logic                           read_en_i,
   output logic                           empty_o,
   output logic                           full_o,
   output logic                           overflow_o,
   output logic                           underflow_o,
   output logic [31:0]                    count_o
);

   localparam int TW = latsc_pkg::TID_WIDTH;
   localparam int W  = TW + HDR_WIDTH + DATA_WIDTH;
   localparam int UW = $clog2(NUM_SLOTS + 1);

   logic [TW-1:0]             tid_q;
   logic                      wr_accept;
   // Input stage
   logic [W-1:0]              in_word;
   logic                      in_valid, in_empty, in_ovf, in_unf, in_pop;
   logic [IN_DEPTH_LOG2:0]    in_count;
   // Filtered request stage
   logic [W-1:0]              q_word;
   logic                      q_push, q_pop, q_valid, q_alm_full, q_empty, q_ovf, q_unf;
   logic [Q_DEPTH_LOG2:0]     q_count;
   // Slots and output stage
   logic [W-1:0]              out_word_in;
   logic                      out_wr, out_alm_full, out_empty, out_ovf, out_unf;
   logic                      slot_empty;
   logic [UW-1:0]             slot_used;
   logic [Q_DEPTH_LOG2:0]     out_count;

   // Tag only writes the input FIFO will take
   assign wr_accept = write_en_i && (in_count < (IN_DEPTH_LOG2 + 1)'(2 ** IN_DEPTH_LOG2));

   always_ff @(posedge clk) begin
      if (rst)
         tid_q <= '0;
      else if (wr_accept)
         tid_q <= tid_q + 1'b1;
   end

   sync_fifo #(.WIDTH(W), .DEPTH_LOG2(IN_DEPTH_LOG2), .FULL_THRESH(IN_FULL_THRESH)) in_fifo (
      .clk(clk), .rst(rst),
      .wr_en_i(write_en_i), .data_i({tid_q, meta_i, data_i}), .rd_en_i(in_pop),
      .data_o(in_word), .valid_o(in_valid), .alm_full_o(full_o), .empty_o(in_empty),
      .count_o(in_count), .overflow_o(in_ovf), .underflow_o(in_unf)
   );

   fence_filter #(.HDR_WIDTH(HDR_WIDTH)) u_fence_filter (
      .clk(clk), .rst(rst),
      .head_meta_i(in_word[DATA_WIDTH +: HDR_WIDTH]),
      .head_valid_i(in_valid),
      .head_empty_i(in_empty),
      .q_alm_full_i(q_alm_full),
      // Every earlier request has left once all downstream stages are empty
      .downstream_empty_i(q_empty && slot_empty && out_empty),
      .pop_o(in_pop),
      .push_o(q_push)
   );

   sync_fifo #(.WIDTH(W), .DEPTH_LOG2(Q_DEPTH_LOG2), .FULL_THRESH(Q_FULL_THRESH)) req_fifo (
      .clk(clk), .rst(rst),
      .wr_en_i(q_push), .data_i(in_word), .rd_en_i(q_pop),
      .data_o(q_word), .valid_o(q_valid), .alm_full_o(q_alm_full), .empty_o(q_empty),
      .count_o(q_count), .overflow_o(q_ovf), .underflow_o(q_unf)
   );

   latency_slot_array #(
      .HDR_WIDTH(HDR_WIDTH), .DATA_WIDTH(DATA_WIDTH),
      .NUM_SLOTS(NUM_SLOTS), .LFSR_SEED(LFSR_SEED)
   ) u_slots (
      .clk(clk), .rst(rst),
      .q_empty_i(q_empty), .q_valid_i(q_valid), .q_word_i(q_word), .q_pop_o(q_pop),
      .out_alm_full_i(out_alm_full), .out_wr_o(out_wr), .out_word_o(out_word_in),
      .empty_o(slot_empty), .used_o(slot_used)
   );

   sync_fifo #(.WIDTH(W), .DEPTH_LOG2(Q_DEPTH_LOG2), .FULL_THRESH(Q_FULL_THRESH)) out_fifo (
      .clk(clk), .rst(rst),
      .wr_en_i(out_wr), .data_i(out_word_in), .rd_en_i(read_en_i),
      .data_o({tid_o, meta_o, data_o}), .valid_o(valid_o), .alm_full_o(out_alm_full),
      .empty_o(out_empty), .count_o(out_count), .overflow_o(out_ovf), .underflow_o(out_unf)
   );

   // Status
   assign empty_o     = out_empty;
   assign overflow_o  = in_ovf || q_ovf || out_ovf;
   assign underflow_o = in_unf || q_unf || out_unf;
   assign count_o     = 32'(in_count) + 32'(q_count) + 32'(slot_used) + 32'(out_count);

endmodule

// ==== design/latency_slot_array.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Latency slot array
//   Request slots, each with a countdown and a slot state
//   Lowest-index free slot, round-robin ready slot selection
//   Galois LFSR delay per request type
//   Pop register feeding the output FIFO, usage status
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module latency_slot_array #(
   parameter int          HDR_WIDTH  = 24,
   parameter int          DATA_WIDTH = 32,
   parameter int          NUM_SLOTS  = 8,
   parameter logic [15:0] LFSR_SEED  = 16'hACE1
) (
   input  logic                                              clk,
   input  logic                                              rst,
   input  logic                                              q_empty_i,
   input  logic                                              q_valid_i,
   input  logic [latsc_pkg::TID_WIDTH+HDR_WIDTH+DATA_WIDTH-1:0] q_word_i,
   output logic                                              q_pop_o,
   input  logic                                              out_alm_full_i,
   output logic                                              out_wr_o,
   output logic [latsc_pkg::TID_WIDTH+HDR_WIDTH+DATA_WIDTH-1:0] out_word_o,
   output logic                                              empty_o,
   output logic [$clog2(NUM_SLOTS+1)-1:0]                    used_o
);

   localparam int W     = latsc_pkg::TID_WIDTH + HDR_WIDTH + DATA_WIDTH;
   localparam int CW    = latsc_pkg::COUNT_WIDTH;
   localparam int IW    = $clog2(NUM_SLOTS);
   localparam int UW    = $clog2(NUM_SLOTS + 1);
   localparam int T_POS = DATA_WIDTH + latsc_pkg::TYPE_LSB;

   latsc_pkg::slot_state_e slot_state_q [NUM_SLOTS];
   logic [W-1:0]           slot_word_q  [NUM_SLOTS];
   logic [CW-1:0]          slot_ctr_q   [NUM_SLOTS];
   logic [15:0]            lfsr_q;
   logic [CW-1:0]          new_delay;
   logic [IW-1:0]          free_idx;
   logic                   free_found;
   logic [IW-1:0]          rdy_idx;
   logic                   rdy_found;
   logic [IW-1:0]          rr_q;
   logic [UW-1:0]          used_cnt;
   logic                   pop_valid_q;
   logic [IW-1:0]          pop_idx_q;
   logic [W-1:0]           pop_word_q;

   // Delay = type minimum plus LFSR folded into the type span
   function automatic logic [CW-1:0] pick_delay(input logic [latsc_pkg::TYPE_WIDTH-1:0] t,
                                                input logic [15:0] r);
      int lo;
      int hi;
      lo = latsc_pkg::LAT_UNDEF;
      hi = latsc_pkg::LAT_UNDEF;
      case (t)
         latsc_pkg::RD_LINE: begin lo = latsc_pkg::LAT_MIN_RD;  hi = latsc_pkg::LAT_MAX_RD;  end
         latsc_pkg::WR_LINE: begin lo = latsc_pkg::LAT_MIN_WR;  hi = latsc_pkg::LAT_MAX_WR;  end
         latsc_pkg::WR_THRU: begin lo = latsc_pkg::LAT_MIN_WT;  hi = latsc_pkg::LAT_MAX_WT;  end
         latsc_pkg::INTR:    begin lo = latsc_pkg::LAT_MIN_INT; hi = latsc_pkg::LAT_MAX_INT; end
         default:            lo = latsc_pkg::LAT_UNDEF;
      endcase
      return CW'(lo + (int'(r) % (hi - lo + 1)));
   endfunction

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   always_ff @(posedge clk) begin
      if (rst)
         lfsr_q <= LFSR_SEED;
      else
         lfsr_q <= {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hB400 : 16'h0000);
   end

   assign new_delay = pick_delay(q_word_i[T_POS +: latsc_pkg::TYPE_WIDTH], lfsr_q);

   // Lowest free slot, slot usage count
   always_comb begin
      free_found = 1'b0;
      free_idx   = '0;
      used_cnt   = '0;
      for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
         if (slot_state_q[i] == latsc_pkg::SLOT_FREE) begin
            free_found = 1'b1;
            free_idx   = IW'(i);
         end else begin
            used_cnt = used_cnt + 1'b1;
         end
      end
   end

   // Ready slot, round robin after the last pop, skipping the one held in the pop register
   always_comb begin
      int idx;
      rdy_found = 1'b0;
      rdy_idx   = rr_q;
      for (int i = 1; i <= NUM_SLOTS; i++) begin
         idx = (int'(rr_q) + i) % NUM_SLOTS;
         if (!rdy_found && slot_state_q[idx] == latsc_pkg::SLOT_READY &&
             !(pop_valid_q && pop_idx_q == IW'(idx))) begin
            rdy_found = 1'b1;
            rdy_idx   = IW'(idx);
         end
      end
   end

   // Keep one slot spare for the word already in flight from the request FIFO
   assign q_pop_o  = !q_empty_i && free_found && (used_cnt < UW'(NUM_SLOTS - 1));
   assign out_wr_o = pop_valid_q && !out_alm_full_i;

   // Slot control
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_SLOTS; i++)
            slot_state_q[i] <= latsc_pkg::SLOT_FREE;
      end else begin
         for (int i = 0; i < NUM_SLOTS; i++) begin
            case (slot_state_q[i])
               latsc_pkg::SLOT_FREE:
                  if (q_valid_i && free_idx == IW'(i))
                     slot_state_q[i] <= latsc_pkg::SLOT_COUNT;
               latsc_pkg::SLOT_COUNT:
                  if (slot_ctr_q[i] == '0)
                     slot_state_q[i] <= latsc_pkg::SLOT_READY;
               // Slot frees itself once the pop register hands it over
               latsc_pkg::SLOT_READY:
                  if (out_wr_o && pop_idx_q == IW'(i))
                     slot_state_q[i] <= latsc_pkg::SLOT_FREE;
               default: slot_state_q[i] <= latsc_pkg::SLOT_FREE;
            endcase
         end
      end
   end

   // Slot payload and countdown
   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
         if (q_valid_i && free_idx == IW'(i) && slot_state_q[i] == latsc_pkg::SLOT_FREE) begin
            slot_word_q[i] <= q_word_i;
            slot_ctr_q[i]  <= new_delay;
         end else if (slot_state_q[i] == latsc_pkg::SLOT_COUNT && slot_ctr_q[i] != '0) begin
            slot_ctr_q[i] <= slot_ctr_q[i] - 1'b1;
         end
      end
   end

   // Pop register, reloads in the same cycle it transfers
   always_ff @(posedge clk) begin
      if (rst) begin
         pop_valid_q <= 1'b0;
         pop_idx_q   <= '0;
         rr_q        <= '0;
      end else if (rdy_found && (!pop_valid_q || out_wr_o)) begin
         pop_valid_q <= 1'b1;
         pop_idx_q   <= rdy_idx;
         rr_q        <= rdy_idx;
      end else if (out_wr_o) begin
         pop_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rdy_found && (!pop_valid_q || out_wr_o))
         pop_word_q <= slot_word_q[rdy_idx];
   end

   assign out_word_o = pop_word_q;
   assign used_o     = used_cnt;
   // Word in flight from the request FIFO counts as occupancy
   assign empty_o    = (used_cnt == '0) && !q_valid_i;

   // Incoming word always lands in a free slot
   push_slot_free: assert property (@(posedge clk) disable iff (rst)
      q_valid_i |-> slot_state_q[free_idx] == latsc_pkg::SLOT_FREE);

endmodule

// ==== design/fence_filter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write-fence filter
//   Head decode against the fence opcode
//   Pass / trap FSM holding a fence until downstream drains
//   Pop control for the input FIFO, push control for the request FIFO
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fence_filter #(
   parameter int HDR_WIDTH = 24
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [HDR_WIDTH-1:0] head_meta_i,
   input  logic                 head_valid_i,
   input  logic                 head_empty_i,
   input  logic                 q_alm_full_i,
   input  logic                 downstream_empty_i,
   output logic                 pop_o,
   output logic                 push_o
);

   typedef enum logic [1:0] {
      PASS,
      FENCE_WAIT,
      FENCE_DONE
   } fence_state_e;

   fence_state_e state_q;
   logic         head_seen_q;
   logic         head_ok;
   logic         is_fence;
   logic         pass_pop;
   logic         push_q;

   // Head word is trustworthy once the FIFO was nonempty and unpopped last cycle
   always_ff @(posedge clk) begin
      if (rst)
         head_seen_q <= 1'b0;
      else
         head_seen_q <= !head_empty_i && !pop_o;
   end

   assign head_ok  = head_seen_q && !head_empty_i;
   assign is_fence = head_ok &&
      (head_meta_i[latsc_pkg::TYPE_LSB +: latsc_pkg::TYPE_WIDTH] == latsc_pkg::WR_FENCE);

   // Ordinary requests flow while the request FIFO has room
   assign pass_pop = (state_q == PASS) && head_ok && !is_fence && !q_alm_full_i;
   // Fence leaves in FENCE_DONE and is never pushed
   assign pop_o    = pass_pop || (state_q == FENCE_DONE);

   // Trap FSM
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= PASS;
      end else begin
         case (state_q)
            PASS: begin
               if (is_fence)
                  state_q <= FENCE_WAIT;
            end
            // Hold until the request FIFO, slots and output FIFO drain
            FENCE_WAIT: begin
               if (downstream_empty_i)
                  state_q <= FENCE_DONE;
            end
            // Pop cycle, the following cycle is spent re-reading the head
            FENCE_DONE: state_q <= PASS;
            default:    state_q <= PASS;
         endcase
      end
   end

   // Push lines up with the read valid of the popped word
   always_ff @(posedge clk) begin
      if (rst)
         push_q <= 1'b0;
      else
         push_q <= pass_pop;
   end

   assign push_o = push_q && head_valid_i;

   // Only a fence head is discarded, and only after the model was seen empty
   fence_pop_after_empty: assert property (@(posedge clk) disable iff (rst)
      (pop_o && state_q == FENCE_DONE) |-> is_fence && $past(downstream_empty_i));

endmodule

// ==== design/sync_fifo.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous FIFO
//   Circular buffer with registered read data and read valid
//   Occupancy count, almost-full threshold, empty flag
//   One-cycle overflow and underflow pulses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sync_fifo #(
   parameter int WIDTH       = 32,
   parameter int DEPTH_LOG2  = 3,
   parameter int FULL_THRESH = 5
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                wr_en_i,
   input  logic [WIDTH-1:0]    data_i,
   input  logic                rd_en_i,
   output logic [WIDTH-1:0]    data_o,
   output logic                valid_o,
   output logic                alm_full_o,
   output logic                empty_o,
   output logic [DEPTH_LOG2:0] count_o,
   output logic                overflow_o,
   output logic                underflow_o
);

   localparam int DEPTH = 2 ** DEPTH_LOG2;
   localparam int CW    = DEPTH_LOG2 + 1;

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr_q;
   logic [DEPTH_LOG2-1:0] rd_ptr_q;
   logic [DEPTH_LOG2:0]   count_q;
   logic                  full;
   logic                  wr_ok;
   logic                  rd_ok;

   assign full       = (count_q == CW'(DEPTH));
   assign empty_o    = (count_q == '0);
   assign alm_full_o = (count_q >= CW'(FULL_THRESH));
   assign count_o    = count_q;
   // Writes when full and reads when empty are dropped
   assign wr_ok      = wr_en_i && !full;
   assign rd_ok      = rd_en_i && !empty_o;

   // Read register samples the head every cycle
   // After a pop it holds the popped word, otherwise the current head
   always_ff @(posedge clk) begin
      if (wr_ok)
         mem[wr_ptr_q] <= data_i;
      data_o <= mem[rd_ptr_q];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr_q    <= '0;
         rd_ptr_q    <= '0;
         count_q     <= '0;
         valid_o     <= 1'b0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         if (wr_ok)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (rd_ok)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         // Occupancy, unchanged on simultaneous read and write
         case ({wr_ok, rd_ok})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         valid_o     <= rd_ok;
         overflow_o  <= wr_en_i && full;
         underflow_o <= rd_en_i && empty_o;
      end
   end

   // Accepted write never lands on an unread entry
   wr_free_entry: assert property (@(posedge clk) disable iff (rst)
      wr_ok |-> (wr_ptr_q != rd_ptr_q) || empty_o);

endmodule

// ==== design/latsc_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the latency scoreboard
//   Request opcodes and the type field position in the header
//   Tracking tag and countdown widths
//   Per-opcode delay bounds in cycles
//   Slot states of the latency slot array
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package latsc_pkg;

   // Request opcodes, 3 bit type field
   typedef enum logic [2:0] {
      RD_LINE  = 3'd1,
      WR_LINE  = 3'd2,
      WR_THRU  = 3'd3,
      WR_FENCE = 3'd4,
      INTR     = 3'd5
   } req_type_e;

   // Type field sits in the low header bits
   localparam int TYPE_LSB   = 0;
   localparam int TYPE_WIDTH = 3;

   // Tracking tag attached at the input
   localparam int TID_WIDTH = 16;

   // Slot countdown width, bounds below must fit
   localparam int COUNT_WIDTH = 8;

   // Delay bounds per opcode
   localparam int LAT_MIN_RD  = 10;
   localparam int LAT_MAX_RD  = 40;
   localparam int LAT_MIN_WR  = 8;
   localparam int LAT_MAX_WR  = 30;
   localparam int LAT_MIN_WT  = 6;
   localparam int LAT_MAX_WT  = 20;
   localparam int LAT_MIN_INT = 4;
   localparam int LAT_MAX_INT = 12;
   // Fixed delay for opcodes without a model
   localparam int LAT_UNDEF   = 16;

   // Slot life cycle
   typedef enum logic [1:0] {
      SLOT_FREE,
      SLOT_COUNT,
      SLOT_READY
   } slot_state_e;

endpackage
